/* rtl/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define ALU_OP_W    12
`define IMM_W       16
`define JIDX_W      26

// primary opcodes
`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// special function codes
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRLV     6'h06
`define FN_SRAV     6'h07
`define FN_JR       6'h08
`define FN_JALR     6'h09
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// regimm rt field
`define RT_BLTZ     5'h00
`define RT_BGEZ     5'h01

`endif

/* rtl/id_pkg.sv */
`default_nettype none

`include "id_defines.svh"

package id_pkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`IMM_W-1:0]      imm_t;
    typedef logic [`JIDX_W-1:0]     jidx_t;
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;   // add sub slt sltu and nor or xor sll srl sra lui

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fs_to_ds_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    load_op;
        logic    mem_we;
        logic    gr_we;
        logic    src1_is_sa;
        logic    src1_is_pc;
        logic    src2_is_imm;
        logic    src2_ext0;
        logic    src2_is_8;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t dest;
        imm_t      imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
    } ds_to_es_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

    typedef struct packed {
        logic beq;
        logic bne;
        logic gez;
        logic gtz;
        logic lez;
        logic ltz;
        logic jump_imm;         // j, jal
        logic jump_reg;         // jr, jalr
    } br_kind_t;

    typedef struct packed {
        reg_addr_t dest;        // 0 = no write
        word_t     result;
        logic      res_from_mem;
    } es_fwd_t;

    typedef struct packed {
        reg_addr_t dest;
        word_t     result;
        logic      ready;
    } ms_fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t dest;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* rtl/ds_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ds_pipe_reg
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    input  logic      es_allowin,
    input  logic      ready_go,
    output logic      ds_allowin,
    output logic      ds_valid,
    output fs_to_ds_t ds_bus
);

    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;   // empty slot or item leaving
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds;
        end
    end

    // a blocked instruction stays in place
    a_hold_when_blocked: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin |=> ds_valid && $stable(ds_bus)
    ) else $error("ds_pipe_reg: blocked instruction changed");

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module inst_decoder
    import id_pkg::*;
(
    input  word_t     inst,
    output ctrl_t     ctrl,
    output reg_addr_t dest,
    output imm_t      imm,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output logic      rs_used,
    output logic      rt_used,
    output br_kind_t  br_kind
);

    logic [5:0] op;
    logic [5:0] func;
    reg_addr_t  rd;
    reg_addr_t  sa;
    logic       special;
    logic       sa_zero;

    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
    logic inst_lui, inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_j, inst_jal, inst_jr, inst_jalr;
    logic dst_is_rt;

    assign op      = inst[31:26];
    assign rs      = inst[25:21];
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];
    assign sa      = inst[10:6];
    assign func    = inst[5:0];
    assign imm     = inst[15:0];
    assign special = (op == `OP_SPECIAL);
    assign sa_zero = (sa == '0);

    assign inst_addu  = special && func == `FN_ADDU && sa_zero;
    assign inst_subu  = special && func == `FN_SUBU && sa_zero;
    assign inst_slt   = special && func == `FN_SLT  && sa_zero;
    assign inst_sltu  = special && func == `FN_SLTU && sa_zero;
    assign inst_and   = special && func == `FN_AND  && sa_zero;
    assign inst_or    = special && func == `FN_OR   && sa_zero;
    assign inst_xor   = special && func == `FN_XOR  && sa_zero;
    assign inst_nor   = special && func == `FN_NOR  && sa_zero;
    assign inst_sll   = special && func == `FN_SLL  && rs == '0;
    assign inst_srl   = special && func == `FN_SRL  && rs == '0;
    assign inst_sra   = special && func == `FN_SRA  && rs == '0;
    assign inst_sllv  = special && func == `FN_SLLV;
    assign inst_srlv  = special && func == `FN_SRLV;
    assign inst_srav  = special && func == `FN_SRAV;
    assign inst_jr    = special && func == `FN_JR && rt == '0 && rd == '0 && sa_zero;
    assign inst_jalr  = special && func == `FN_JALR && rt == '0 && sa_zero;
    assign inst_addiu = (op == `OP_ADDIU);
    assign inst_slti  = (op == `OP_SLTI);
    assign inst_sltiu = (op == `OP_SLTIU);
    assign inst_andi  = (op == `OP_ANDI);
    assign inst_ori   = (op == `OP_ORI);
    assign inst_xori  = (op == `OP_XORI);
    assign inst_lui   = (op == `OP_LUI) && rs == '0;
    assign inst_lw    = (op == `OP_LW);
    assign inst_sw    = (op == `OP_SW);
    assign inst_beq   = (op == `OP_BEQ);
    assign inst_bne   = (op == `OP_BNE);
    assign inst_bgez  = (op == `OP_REGIMM) && rt == `RT_BGEZ;
    assign inst_bltz  = (op == `OP_REGIMM) && rt == `RT_BLTZ;
    assign inst_bgtz  = (op == `OP_BGTZ) && rt == '0;
    assign inst_blez  = (op == `OP_BLEZ) && rt == '0;
    assign inst_j     = (op == `OP_J);
    assign inst_jal   = (op == `OP_JAL);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[0]   = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr;
        ctrl.alu_op[1]   = inst_subu;
        ctrl.alu_op[2]   = inst_slt | inst_slti;
        ctrl.alu_op[3]   = inst_sltu | inst_sltiu;
        ctrl.alu_op[4]   = inst_and | inst_andi;
        ctrl.alu_op[5]   = inst_nor;
        ctrl.alu_op[6]   = inst_or | inst_ori;
        ctrl.alu_op[7]   = inst_xor | inst_xori;
        ctrl.alu_op[8]   = inst_sll | inst_sllv;
        ctrl.alu_op[9]   = inst_srl | inst_srlv;
        ctrl.alu_op[10]  = inst_sra | inst_srav;
        ctrl.alu_op[11]  = inst_lui;
        ctrl.load_op     = inst_lw;
        ctrl.mem_we      = inst_sw;
        ctrl.src1_is_sa  = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc  = inst_jal | inst_jalr;          // link address
        ctrl.src2_is_imm = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                         | inst_xori | inst_lui | inst_lw | inst_sw;
        ctrl.src2_ext0   = inst_andi | inst_ori | inst_xori;
        ctrl.src2_is_8   = inst_jal | inst_jalr;
        // every writing op except sw and branches; unknown opcodes fall out as zero
        ctrl.gr_we       = (|ctrl.alu_op) & ~inst_sw;
    end

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | inst_lw;

    assign dest = !ctrl.gr_we ? 5'd0  :
                  inst_jal    ? 5'd31 :
                  dst_is_rt   ? rt    :
                                rd;

    assign rs_used = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_xor | inst_nor | inst_sllv | inst_srlv | inst_srav
                   | inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori
                   | inst_lw | inst_sw | inst_beq | inst_bne | inst_bgez | inst_bgtz
                   | inst_blez | inst_bltz | inst_jr | inst_jalr;
    assign rt_used = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra
                   | inst_sllv | inst_srlv | inst_srav | inst_sw | inst_beq | inst_bne;

    assign br_kind = '{beq: inst_beq, bne: inst_bne, gez: inst_bgez, gtz: inst_bgtz,
                       lez: inst_blez, ltz: inst_bltz, jump_imm: inst_j | inst_jal,
                       jump_reg: inst_jr | inst_jalr};

    always_comb begin
        if (!$isunknown(ctrl.alu_op)) begin
            a_alu_op_onehot: assert ($onehot0(ctrl.alu_op))
                else $error("inst_decoder: alu_op %h not one-hot", ctrl.alu_op);
        end
    end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module regfile
    import id_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  wb_t       wb
);

    word_t rf [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (wb.we && wb.dest != '0) begin
            rf[wb.dest] <= wb.data;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* rtl/operand_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
    import id_pkg::*;
(
    input  logic      ds_valid,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      rs_used,
    input  logic      rt_used,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  es_fwd_t   es_fwd,
    input  ms_fwd_t   ms_fwd,
    input  wb_t       wb,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      ready_go
);

    logic rs_es, rs_ms, rs_wb;
    logic rt_es, rt_ms, rt_wb;
    logic stall;

    function automatic logic src_hit(reg_addr_t src, logic used, reg_addr_t dest);
        return used && (src != '0) && (src == dest);
    endfunction

    assign rs_es = src_hit(rs, rs_used, es_fwd.dest);
    assign rs_ms = src_hit(rs, rs_used, ms_fwd.dest);
    assign rs_wb = src_hit(rs, rs_used, wb.dest) && wb.we;
    assign rt_es = src_hit(rt, rt_used, es_fwd.dest);
    assign rt_ms = src_hit(rt, rt_used, ms_fwd.dest);
    assign rt_wb = src_hit(rt, rt_used, wb.dest) && wb.we;

    // youngest producer wins
    assign rs_value = rs_es ? es_fwd.result :
                      rs_ms ? ms_fwd.result :
                      rs_wb ? wb.data       :
                              rf_rdata1;
    assign rt_value = rt_es ? es_fwd.result :
                      rt_ms ? ms_fwd.result :
                      rt_wb ? wb.data       :
                              rf_rdata2;

    assign stall = ((rs_es || rt_es) && es_fwd.res_from_mem)   // load still in execute
                || ((rs_ms || rt_ms) && !ms_fwd.ready);

    always_comb begin
        ready_go = ds_valid && !stall;
        if (!$isunknown(ready_go)) begin
            a_no_go_on_es_load: assert (!(ready_go && es_fwd.res_from_mem
                && ((rs_used && rs != '0 && rs == es_fwd.dest)
                    || (rt_used && rt != '0 && rt == es_fwd.dest))))
                else $error("operand_bypass: operand taken from a load in execute");
        end
    end

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module branch_unit
    import id_pkg::*;
(
    input  logic     ready_go,
    input  br_kind_t br_kind,
    input  word_t    pc,
    input  imm_t     imm,
    input  jidx_t    jidx,
    input  word_t    rs_value,
    input  word_t    rt_value,
    output br_t      br
);

    word_t seq_pc;
    word_t br_off;
    logic  rs_eq_rt;
    logic  rs_eq_z;
    logic  rs_lt_z;
    logic  rs_gt_z;
    logic  cond;

    assign seq_pc = pc + 32'd4;   // delay slot pc
    assign br_off = {{(`DATA_W - `IMM_W - 2){imm[`IMM_W-1]}}, imm, 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_eq_z  = (rs_value == '0);
    assign rs_lt_z  = rs_value[`DATA_W-1];
    assign rs_gt_z  = !rs_lt_z && !rs_eq_z;

    assign cond = (br_kind.beq && rs_eq_rt)
               || (br_kind.bne && !rs_eq_rt)
               || (br_kind.gez && !rs_lt_z)
               || (br_kind.gtz && rs_gt_z)
               || (br_kind.lez && (rs_lt_z || rs_eq_z))
               || (br_kind.ltz && rs_lt_z)
               || br_kind.jump_imm
               || br_kind.jump_reg;

    assign br.taken  = cond && ready_go;
    assign br.target = br_kind.jump_reg ? rs_value :
                       br_kind.jump_imm ? {seq_pc[`DATA_W-1:`DATA_W-4], jidx, 2'b00} :
                                          seq_pc + br_off;

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es,
    output br_t       br,
    input  es_fwd_t   es_fwd,
    input  ms_fwd_t   ms_fwd,
    input  wb_t       wb
);

    logic      ds_valid;
    logic      ready_go;
    fs_to_ds_t ds_bus;

    ctrl_t     ctrl;
    reg_addr_t dest;
    imm_t      imm;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      rs_used;
    logic      rt_used;
    br_kind_t  br_kind;

    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rs_value;
    word_t     rt_value;

    ds_pipe_reg u_ds_pipe_reg (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .es_allowin     (es_allowin),
        .ready_go       (ready_go),
        .ds_allowin     (ds_allowin),
        .ds_valid       (ds_valid),
        .ds_bus         (ds_bus)
    );

    inst_decoder u_inst_decoder (
        .inst    (ds_bus.inst),
        .ctrl    (ctrl),
        .dest    (dest),
        .imm     (imm),
        .rs      (rs),
        .rt      (rt),
        .rs_used (rs_used),
        .rt_used (rt_used),
        .br_kind (br_kind)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wb     (wb)
    );

    operand_bypass u_operand_bypass (
        .ds_valid  (ds_valid),
        .rs        (rs),
        .rt        (rt),
        .rs_used   (rs_used),
        .rt_used   (rt_used),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .wb        (wb),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .ready_go  (ready_go)
    );

    branch_unit u_branch_unit (
        .ready_go (ready_go),
        .br_kind  (br_kind),
        .pc       (ds_bus.pc),
        .imm      (imm),
        .jidx     (ds_bus.inst[`JIDX_W-1:0]),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br)
    );

    assign ds_to_es_valid = ready_go;
    assign ds_to_es = '{ctrl: ctrl, dest: dest, imm: imm, rs_value: rs_value,
                        rt_value: rt_value, pc: ds_bus.pc};

endmodule

`default_nettype wire

/* bench/id_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
    import id_pkg::*;
();

    typedef struct packed {
        ds_to_es_t bus;
        br_t       br;
        logic      stall;
        logic      has_target;
    } exp_t;

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    br_t       br;
    es_fwd_t   es_fwd;
    ms_fwd_t   ms_fwd;
    wb_t       wb;

    logic [15:0] lfsr = 16'd53;
    word_t       shadow [32];
    word_t       pc_reg;
    logic        held = 1'b0;
    word_t       held_inst;
    word_t       held_pc;
    int          accept_cnt = 0;
    int          xfer_cnt = 0;
    int          checks = 0;
    int          errors = 0;
    int          chk0 = 0;
    int          err0 = 0;

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .br             (br),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .wb             (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t gen_alu_inst();
        word_t f;
        word_t r;
        int    sel;
        f = rand_bits(32);
        r = rand_bits(5);
        sel = int'(r % 32'd23);
        case (sel)
            0:  return {6'h00, f[25:11], 5'h00, 6'h21};
            1:  return {6'h00, f[25:11], 5'h00, 6'h23};
            2:  return {6'h00, f[25:11], 5'h00, 6'h2a};
            3:  return {6'h00, f[25:11], 5'h00, 6'h2b};
            4:  return {6'h00, f[25:11], 5'h00, 6'h24};
            5:  return {6'h00, f[25:11], 5'h00, 6'h25};
            6:  return {6'h00, f[25:11], 5'h00, 6'h26};
            7:  return {6'h00, f[25:11], 5'h00, 6'h27};
            8:  return {6'h00, 5'h00, f[20:6], 6'h00};
            9:  return {6'h00, 5'h00, f[20:6], 6'h02};
            10: return {6'h00, 5'h00, f[20:6], 6'h03};
            11: return {6'h00, f[25:11], 5'h00, 6'h04};
            12: return {6'h00, f[25:11], 5'h00, 6'h06};
            13: return {6'h00, f[25:11], 5'h00, 6'h07};
            14: return {6'h09, f[25:0]};
            15: return {6'h0a, f[25:0]};
            16: return {6'h0b, f[25:0]};
            17: return {6'h0c, f[25:0]};
            18: return {6'h0d, f[25:0]};
            19: return {6'h0e, f[25:0]};
            20: return {6'h0f, 5'h00, f[20:0]};
            21: return {6'h23, f[25:0]};
            default: return {6'h2b, f[25:0]};
        endcase
    endfunction

    function automatic word_t gen_branch_inst();
        word_t     f;
        word_t     r;
        int        sel;
        reg_addr_t rt;
        f = rand_bits(32);
        r = rand_bits(4);
        sel = int'(r % 32'd10);
        rt = f[31] ? f[25:21] : f[20:16];   // equal operands half the time
        case (sel)
            0: return {6'h04, f[25:21], rt, f[15:0]};
            1: return {6'h05, f[25:21], rt, f[15:0]};
            2: return {6'h06, f[25:21], 5'h00, f[15:0]};
            3: return {6'h07, f[25:21], 5'h00, f[15:0]};
            4: return {6'h01, f[25:21], 5'h00, f[15:0]};
            5: return {6'h01, f[25:21], 5'h01, f[15:0]};
            6: return {6'h02, f[25:0]};
            7: return {6'h03, f[25:0]};
            8: return {6'h00, f[25:21], 15'h0000, 6'h08};
            default: return {6'h00, f[25:21], 5'h00, f[15:11], 5'h00, 6'h09};
        endcase
    endfunction

    function automatic word_t src_val(reg_addr_t r, logic used);
        if (used && r != 5'd0) begin
            if (r == es_fwd.dest) return es_fwd.result;
            if (r == ms_fwd.dest) return ms_fwd.result;
            if (wb.we && r == wb.dest) return wb.data;
        end
        return shadow[r];
    endfunction

    function automatic logic src_stall(reg_addr_t r, logic used);
        return used && r != 5'd0 && ((r == es_fwd.dest && es_fwd.res_from_mem)
                                  || (r == ms_fwd.dest && !ms_fwd.ready));
    endfunction

    function automatic exp_t ref_model(word_t inst, word_t pc);
        exp_t       e;
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rs, rt, rd, sa;
        int         ab;
        int         bk;
        logic       ok, use_rs, use_rt, imm_op, s2imm, dst_rt, ext0, lnk, jal_k;
        logic       ld, st, sa_op, jr_k, j_k, cond;
        word_t      a, b, seq;
        e = '0;
        ab = -1;
        bk = 0;
        {use_rs, use_rt, imm_op, s2imm, dst_rt, ext0, lnk, jal_k} = '0;
        {ld, st, sa_op, jr_k, j_k, cond} = '0;
        op = inst[31:26];
        rs = inst[25:21];
        rt = inst[20:16];
        rd = inst[15:11];
        sa = inst[10:6];
        fn = inst[5:0];
        case (op)
            6'h00: begin
                case (fn)
                    6'h21: ab = 0;
                    6'h23: ab = 1;
                    6'h2a: ab = 2;
                    6'h2b: ab = 3;
                    6'h24: ab = 4;
                    6'h27: ab = 5;
                    6'h25: ab = 6;
                    6'h26: ab = 7;
                    6'h00, 6'h04: ab = 8;
                    6'h02, 6'h06: ab = 9;
                    6'h03, 6'h07: ab = 10;
                    6'h08: jr_k = 1'b1;
                    6'h09: begin
                        jr_k = 1'b1;
                        lnk = 1'b1;
                        ab = 0;
                    end
                    default: ;
                endcase
                ok = (fn == 6'h00 || fn == 6'h02 || fn == 6'h03) ? rs == 5'd0 :
                     (fn == 6'h08) ? (rt == 5'd0 && rd == 5'd0 && sa == 5'd0) :
                     (fn == 6'h09) ? (rt == 5'd0 && sa == 5'd0) :
                     (fn == 6'h04 || fn == 6'h06 || fn == 6'h07) ? 1'b1 : sa == 5'd0;
                if (!ok) begin
                    ab = -1;
                    jr_k = 1'b0;
                    lnk = 1'b0;
                end
                sa_op = ab >= 8 && !fn[2];
                if (ab >= 0 && !lnk) begin
                    use_rt = 1'b1;
                    use_rs = !sa_op;
                end
                if (jr_k) use_rs = 1'b1;
            end
            6'h01: bk = (rt == 5'd0) ? 6 : (rt == 5'd1) ? 3 : 0;
            6'h04: bk = 1;
            6'h05: bk = 2;
            6'h06: bk = (rt == 5'd0) ? 5 : 0;
            6'h07: bk = (rt == 5'd0) ? 4 : 0;
            6'h02: j_k = 1'b1;
            6'h03: begin
                j_k = 1'b1;
                lnk = 1'b1;
                jal_k = 1'b1;
                ab = 0;
            end
            6'h09: ab = 0;
            6'h0a: ab = 2;
            6'h0b: ab = 3;
            6'h0c: ab = 4;
            6'h0d: ab = 6;
            6'h0e: ab = 7;
            6'h0f: begin
                if (rs == 5'd0) begin
                    ab = 11;
                    s2imm = 1'b1;
                    dst_rt = 1'b1;
                end
            end
            6'h23: begin
                ab = 0;
                ld = 1'b1;
            end
            6'h2b: begin
                ab = 0;
                st = 1'b1;
                use_rt = 1'b1;
            end
            default: ;
        endcase
        imm_op = op inside {6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h23, 6'h2b};
        ext0 = op inside {6'h0c, 6'h0d, 6'h0e};   // zero-extended logic immediates
        if (imm_op) begin
            use_rs = 1'b1;
            s2imm = 1'b1;
            dst_rt = !st;
        end
        if (bk == 1 || bk == 2) use_rt = 1'b1;
        if (bk != 0) use_rs = 1'b1;

        if (ab >= 0) e.bus.ctrl.alu_op[ab] = 1'b1;
        e.bus.ctrl.load_op     = ld;
        e.bus.ctrl.mem_we      = st;
        e.bus.ctrl.gr_we       = ab >= 0 && !st;
        e.bus.ctrl.src1_is_sa  = sa_op;
        e.bus.ctrl.src1_is_pc  = lnk;
        e.bus.ctrl.src2_is_imm = s2imm;
        e.bus.ctrl.src2_ext0   = ext0;
        e.bus.ctrl.src2_is_8   = lnk;
        e.bus.dest = !e.bus.ctrl.gr_we ? 5'd0 : jal_k ? 5'd31 : dst_rt ? rt : rd;
        e.bus.imm  = inst[15:0];
        e.bus.pc   = pc;
        a = src_val(rs, use_rs);
        b = src_val(rt, use_rt);
        e.bus.rs_value = a;
        e.bus.rt_value = b;
        e.stall = src_stall(rs, use_rs) || src_stall(rt, use_rt);

        seq = pc + 32'd4;
        case (bk)
            1: cond = a == b;
            2: cond = a != b;
            3: cond = !a[31];
            4: cond = !a[31] && a != 32'd0;
            5: cond = a[31] || a == 32'd0;
            6: cond = a[31];
            default: cond = j_k || jr_k;
        endcase
        e.br.taken = cond && !e.stall;
        e.br.target = jr_k ? a :
                      j_k  ? {seq[31:28], inst[25:0], 2'b00} :
                             seq + {{14{inst[15]}}, inst[15:0], 2'b00};
        e.has_target = bk != 0 || j_k || jr_k;
        return e;
    endfunction

    task automatic check_val(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(string what);
        errors++;
        $display("Timeout while waiting for %s", what);
    endtask

    // shadow copy of the register file
    always @(posedge clk) begin
        if (wb.we && wb.dest != 5'd0) shadow[wb.dest] <= wb.data;
    end

    // compares with pre-edge values, then tracks the held instruction
    always @(posedge clk) begin : compare_outputs
        exp_t e;
        if (reset) begin
            held <= 1'b0;
        end else begin
            if (held) begin
                e = ref_model(held_inst, held_pc);
                check_val("ds_allowin", 32'(ds_allowin), 32'(!e.stall && es_allowin));
                check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'(!e.stall));
                check_val("br.taken", 32'(br.taken), 32'(e.br.taken));
                if (!e.stall) begin
                    check_val("ds_to_es.ctrl", 32'(ds_to_es.ctrl), 32'(e.bus.ctrl));
                    check_val("ds_to_es.dest", 32'(ds_to_es.dest), 32'(e.bus.dest));
                    check_val("ds_to_es.imm", 32'(ds_to_es.imm), 32'(e.bus.imm));
                    check_val("ds_to_es.rs_value", ds_to_es.rs_value, e.bus.rs_value);
                    check_val("ds_to_es.rt_value", ds_to_es.rt_value, e.bus.rt_value);
                    check_val("ds_to_es.pc", ds_to_es.pc, e.bus.pc);
                    if (e.has_target) check_val("br.target", br.target, e.br.target);
                end
            end else begin
                check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
                check_val("ds_allowin", 32'(ds_allowin), 32'd1);
                check_val("br.taken", 32'(br.taken), 32'd0);
            end
            if (ds_to_es_valid && es_allowin) begin
                held <= 1'b0;
                xfer_cnt <= xfer_cnt + 1;
            end
            if (fs_to_ds_valid && ds_allowin) begin
                held <= 1'b1;
                held_inst <= fs_to_ds.inst;
                held_pc <= fs_to_ds.pc;
                accept_cnt <= accept_cnt + 1;
            end
        end
    end

    task automatic send_inst(word_t inst);
        int    n;
        int    base;
        word_t r;
        base = accept_cnt;
        r = rand_bits(30);
        pc_reg = {r[29:0], 2'b00};
        fs_to_ds_valid = 1'b1;
        fs_to_ds = '{inst: inst, pc: pc_reg};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (accept_cnt == base && n < 20);
        fs_to_ds_valid = 1'b0;
        if (accept_cnt == base) report_timeout("instruction acceptance");
    endtask

    task automatic wait_xfer();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (xfer_cnt != accept_cnt && n < 20);
        if (xfer_cnt != accept_cnt) report_timeout("transfer to execute");
    endtask

    task automatic finish_test(string name);
        $display("%-16s checks %0d errors %0d", name, checks - chk0, errors - err0);
        chk0 = checks;
        err0 = errors;
    endtask

    initial begin
        exp_t  e;
        word_t r;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        ms_fwd = '{dest: 5'd0, result: 32'd0, ready: 1'b1};
        wb = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
        check_val("br.taken", 32'(br.taken), 32'd0);
        check_val("ds_allowin", 32'(ds_allowin), 32'd1);
        finish_test("reset");

        for (int i = 0; i < 32; i++) begin
            wb = '{we: 1'b1, dest: 5'(i), data: rand_bits(32)};
            @(negedge clk);
        end
        wb = '0;
        send_inst({6'h00, 5'd0, 5'd0, 5'd3, 5'h00, 6'h21});  // r0 reads zero
        wait_xfer();
        for (int i = 0; i < 12; i++) begin
            r = rand_bits(15);
            send_inst({6'h00, r[14:0], 5'h00, 6'h21});
            wait_xfer();
        end
        finish_test("register file");

        for (int i = 0; i < 40; i++) begin
            send_inst(gen_alu_inst());
            wait_xfer();
        end
        finish_test("decode");

        es_fwd = '{dest: 5'd5, result: rand_bits(32), res_from_mem: 1'b0};
        ms_fwd = '{dest: 5'd5, result: rand_bits(32), ready: 1'b1};
        for (int i = 0; i < 3; i++) begin
            send_inst({6'h00, 5'd5, 5'd5, 5'd8, 5'h00, 6'h23});
            wb = '{we: 1'b1, dest: 5'd5, data: rand_bits(32)};   // not yet in the file
            wait_xfer();
            wb = '0;
            if (i == 0) es_fwd.dest = 5'd0;
            else ms_fwd.dest = 5'd0;
        end
        finish_test("forwarding");

        es_fwd = '{dest: 5'd7, result: rand_bits(32), res_from_mem: 1'b1};
        send_inst({6'h00, 5'd7, 5'd2, 5'd4, 5'h00, 6'h21});
        repeat (3) @(negedge clk);
        check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
        check_val("ds_allowin", 32'(ds_allowin), 32'd0);
        es_fwd = '0;
        wait_xfer();
        ms_fwd = '{dest: 5'd9, result: rand_bits(32), ready: 1'b0};
        send_inst({6'h2b, 5'd1, 5'd9, 16'h0010});
        repeat (3) @(negedge clk);
        check_val("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
        check_val("ds_allowin", 32'(ds_allowin), 32'd0);
        ms_fwd.ready = 1'b1;
        wait_xfer();
        ms_fwd = '{dest: 5'd0, result: 32'd0, ready: 1'b1};
        finish_test("stall");

        for (int i = 0; i < 30; i++) begin
            send_inst(gen_branch_inst());
            wait_xfer();
        end
        es_allowin = 1'b0;
        send_inst(gen_branch_inst());
        repeat (4) @(negedge clk);
        e = ref_model(held_inst, held_pc);
        checks++;
        if (ds_to_es !== e.bus) begin
            errors++;
            $display("Mismatch ds_to_es: got %h expected %h", ds_to_es, e.bus);
        end
        check_val("br.taken", 32'(br.taken), 32'(e.br.taken));
        check_val("br.target", br.target, e.br.target);
        check_val("ds_allowin", 32'(ds_allowin), 32'd0);
        es_allowin = 1'b1;
        wait_xfer();
        finish_test("branches");

        $display("total checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/id_pkg.sv
rtl/ds_pipe_reg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/id_stage.sv
bench/id_stage_tb.sv

/* run.sh */
#!/bin/bash
# build and run the id_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module id_stage_tb -Mdir obj_dir \
    && ./obj_dir/Vid_stage_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
